// ==== dv/cart_loader_tb.sv ====
//====================
// Cartridge loader testbench
// Header, cheat, backup RAM and backup transfer checks
//====================
`timescale 1ns/10ps
`include "cart_macros.svh"

module cart_loader_tb;

	localparam int CLK_NS      = 40;
	localparam int DRIVE_DELAY = 1;
	localparam int N_SECTORS   = 4;
	localparam int TEST_CYCLES = 256 + 1024 + 2 * (64 + N_SECTORS * (`SECTOR_WORDS + 2));

	logic                   clk_sys;
	logic                   reset;
	cart_pkg::dl_word_t     dl;
	cart_pkg::header_mode_t header_mode;
	cart_pkg::image_t       image;
	cart_pkg::bk_cmd_t      cmd;
	cart_pkg::bsram_req_t   console;
	logic [7:0]             console_q;
	cart_pkg::buf_req_t     buf_req;
	logic [15:0]            buf_q;
	cart_pkg::sector_req_t  sector_req;
	logic                   credit_return;
	cart_pkg::rom_info_t    rom_info;
	cart_pkg::cheat_code_t  cheat;
	logic                   cheat_valid;
	logic                   bk_busy;
	logic                   bk_loading;
	logic                   bk_pending;

	// Reference model state
	logic [31:0]            rng;
	logic                   cart_word;
	logic                   code_word;
	logic [7:0]             m_sizes;
	logic [7:0]             m_sizes_nx;
	cart_pkg::rom_info_t    m_info;
	cart_pkg::cheat_code_t  exp_cheat;
	logic                   m_cheat_valid;
	int                     cheat_pulses;
	logic [7:0]             shadow [2**`BSRAM_BITS];
	logic                   console_rd_q;
	logic [7:0]             console_exp;
	logic                   buf_rd;
	logic                   buf_rd_q;
	logic [15:0]            buf_exp;
	int                     outstanding;
	int                     req_seen;
	int                     credits_back;
	logic                   xfer_on;
	logic                   last_return;
	logic                   exp_write;
	logic                   pending_armed;

	tb_clock_gen i_clock_gen (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	cart_loader_top i_dut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl            (dl),
		.header_mode   (header_mode),
		.image         (image),
		.cmd           (cmd),
		.console       (console),
		.console_q     (console_q),
		.buf_req       (buf_req),
		.buf_q         (buf_q),
		.sector_req    (sector_req),
		.credit_return (credit_return),
		.rom_info      (rom_info),
		.cheat         (cheat),
		.cheat_valid   (cheat_valid),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending)
	);

	task automatic report_failure(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] rand_word();
		rng = xorshift32(rng);
		return rng[15:0];
	endfunction

	//====================
	// Header rules
	//====================
	// Returns {ram size, rom size} after one cartridge word
	function automatic logic [7:0] next_sizes(input cart_pkg::header_mode_t mode,
			input cart_pkg::dl_word_t w, input logic [7:0] cur);
		logic [3:0]  rom;
		logic [3:0]  ram;
		logic [23:0] fld;
		logic        fixed;
		{ram, rom} = cur;
		fixed = 1'b1;
		case (mode)
			cart_pkg::HDR_LOROM:   fld = `CART_LOROM_HDR + `CART_COPIER_OFS;
			cart_pkg::HDR_HIROM:   fld = `CART_HIROM_HDR + `CART_COPIER_OFS;
			cart_pkg::HDR_EXHIROM: fld = `CART_EXHIROM_HDR + `CART_COPIER_OFS;
			default: begin
				fld   = '0;
				fixed = 1'b0;
			end
		endcase
		if (w.addr == '0) begin
			rom = `CART_DEFAULT_ROM_SIZE;
			ram = 4'h0;
			if (mode == cart_pkg::HDR_AUTO && w.data[7:0] != 8'h00) begin
				ram = w.data[7:4];
				rom = w.data[3:0];
			end
		end
		if (fixed && w.addr == fld) begin
			rom = w.data[11:8];
		end
		if (fixed && w.addr == fld + 24'd2) begin
			ram = w.data[3:0];
		end
		return {ram, rom};
	endfunction

	function automatic logic [23:0] size_mask(input logic [3:0] size);
		logic [23:0] m;
		m = 24'd1024 << size;
		return m - 24'd1;
	endfunction

	assign cart_word  = dl.wr && (dl.target == cart_pkg::DL_CART);
	assign code_word  = dl.wr && (dl.target == cart_pkg::DL_CODE);
	assign m_sizes_nx = next_sizes(header_mode, dl, m_sizes);

	always @(posedge clk_sys) begin
		if (!reset) begin
			m_sizes <= '0;
			m_info  <= '0;
		end else if (cart_word) begin
			m_sizes         <= m_sizes_nx;
			m_info.rom_mask <= size_mask(m_sizes_nx[3:0]);
			m_info.ram_mask <= (m_sizes_nx[7:4] == 4'h0) ? '0 : size_mask(m_sizes_nx[7:4]);
			if (dl.addr == '0) begin
				case (header_mode)
					cart_pkg::HDR_HIROM:   m_info.rom_type <= 8'd1;
					cart_pkg::HDR_EXHIROM: m_info.rom_type <= 8'd2;
					cart_pkg::HDR_AUTO:    m_info.rom_type <= dl.data[15:8];
					default:               m_info.rom_type <= 8'd0;
				endcase
			end
			if (dl.addr == 24'd2) begin
				m_info.region <= dl.data[8];
			end
		end
	end

	always @(posedge clk_sys) begin
		if (!reset) begin
			m_cheat_valid <= 1'b0;
			cheat_pulses  <= 0;
		end else begin
			m_cheat_valid <= code_word && dl.addr[3:0] == 4'd14;
			cheat_pulses  <= cheat_pulses + int'(cheat_valid);
		end
	end

	//====================
	// Backup memory model
	//====================
	always @(posedge clk_sys) begin
		console_rd_q <= console.ce && !console.we;
		console_exp  <= shadow[console.addr[`BSRAM_BITS-1:0]];
		buf_rd_q     <= buf_rd;
		buf_exp      <= {shadow[{buf_req.lba[7:0], buf_req.word, 1'b1}],
			shadow[{buf_req.lba[7:0], buf_req.word, 1'b0}]};
		// Each byte takes its own address low byte
		if (cart_word) begin
			shadow[{dl.addr[`BSRAM_BITS-1:1], 1'b0}] <= {dl.addr[7:1], 1'b0};
			shadow[{dl.addr[`BSRAM_BITS-1:1], 1'b1}] <= {dl.addr[7:1], 1'b1};
		end
		if (console.ce && console.we) begin
			shadow[console.addr[`BSRAM_BITS-1:0]] <= console.data;
		end
		if (buf_req.wr) begin
			shadow[{buf_req.lba[7:0], buf_req.word, 1'b0}] <= buf_req.data[7:0];
			shadow[{buf_req.lba[7:0], buf_req.word, 1'b1}] <= buf_req.data[15:8];
		end
	end

	// Storage link bookkeeping
	assign last_return = credit_return && (credits_back == N_SECTORS - 1);

	always @(posedge clk_sys) begin
		if (!reset) begin
			outstanding  <= 0;
			req_seen     <= 0;
			credits_back <= 0;
			xfer_on      <= 1'b0;
		end else begin
			outstanding <= outstanding + int'(sector_req.valid) - int'(credit_return);
			if (last_return) begin
				req_seen     <= 0;
				credits_back <= 0;
				xfer_on      <= 1'b0;
			end else begin
				req_seen     <= req_seen + int'(sector_req.valid);
				credits_back <= credits_back + int'(credit_return);
				if (sector_req.valid) begin
					xfer_on <= 1'b1;
				end
			end
		end
	end

	//====================
	// Checks
	//====================
	assert property (@(posedge clk_sys) !(reset && !$past(reset)) ||
		(!sector_req.valid && !cheat_valid && !bk_busy && !bk_loading && !bk_pending &&
		rom_info.rom_mask == '0 && rom_info.ram_mask == '0 &&
		i_dut.i_backup_sequencer.credits == `BK_CREDITS))
		else report_failure("outputs not at reset values after reset");
	assert property (@(posedge clk_sys) disable iff (!reset) rom_info == m_info)
		else report_failure("rom_info differs from header rules");
	assert property (@(posedge clk_sys) disable iff (!reset) cheat_valid == m_cheat_valid)
		else report_failure("cheat_valid not one cycle after offset 14");
	assert property (@(posedge clk_sys) disable iff (!reset) !cheat_valid || cheat == exp_cheat)
		else report_failure("cheat code fields wrong");
	assert property (@(posedge clk_sys) disable iff (!reset)
		!console_rd_q || console_q == console_exp)
		else report_failure("console read data wrong");
	assert property (@(posedge clk_sys) disable iff (!reset) !buf_rd_q || buf_q == buf_exp)
		else report_failure("storage read data wrong");
	assert property (@(posedge clk_sys) disable iff (!reset)
		!sector_req.valid || outstanding < `BK_CREDITS)
		else report_failure("sector request issued without a credit");
	assert property (@(posedge clk_sys) disable iff (!reset) !sector_req.valid ||
		(sector_req.lba == 15'(req_seen) && sector_req.write == exp_write))
		else report_failure("sector request out of order or wrong direction");
	assert property (@(posedge clk_sys) disable iff (!reset) !xfer_on || bk_busy)
		else report_failure("bk_busy low during a transfer");
	assert property (@(posedge clk_sys) disable iff (!reset)
		!(xfer_on && !exp_write) || bk_loading)
		else report_failure("bk_loading low during a load");
	assert property (@(posedge clk_sys) disable iff (!reset)
		!$past(last_return) || (!bk_busy && !bk_loading))
		else report_failure("transfer not over after the last credit");
	assert property (@(posedge clk_sys) disable iff (!reset)
		!$past(console.ce && console.we && !cmd.osd_open && pending_armed) || bk_pending)
		else report_failure("console write did not set bk_pending");
	assert property (@(posedge clk_sys) disable iff (!reset) !sector_req.valid || !bk_pending)
		else report_failure("bk_pending not cleared at transfer start");

	//====================
	// Stimulus
	//====================
	task automatic step();
		@(posedge clk_sys);
		#(DRIVE_DELAY);
	endtask

	task automatic put_word(input cart_pkg::dl_target_t tgt, input logic [23:0] addr,
			input logic [15:0] data);
		dl.wr     = 1'b1;
		dl.target = tgt;
		dl.addr   = addr;
		dl.data   = data;
		step();
		dl.wr = 1'b0;
	endtask

	task automatic console_access(input logic we, input logic [19:0] addr,
			input logic [7:0] data);
		console.ce   = 1'b1;
		console.we   = we;
		console.addr = addr;
		console.data = data;
		step();
		console.ce = 1'b0;
		console.we = 1'b0;
	endtask

	task automatic send_cheat(input logic [23:0] base);
		for (int k = 0; k < 8; k++) begin
			exp_cheat[16*k +: 16] = rand_word();
		end
		// flags, addr, compare, replace, low half first
		for (int k = 0; k < 8; k++) begin
			put_word(cart_pkg::DL_CODE, base + 24'(2 * k),
				exp_cheat[96 - 32 * (k / 2) + 16 * (k % 2) +: 16]);
		end
		repeat (3) step();
	endtask

	// Storage side, holding credits back before the first sector
	task automatic serve_sectors(input logic is_load);
		repeat (24) step();
		assert (req_seen == `BK_CREDITS)
			else report_failure("requests at zero credits differ from the credit count");
		for (int s = 0; s < N_SECTORS; s++) begin
			while (req_seen <= s) begin
				step();
			end
			for (int w = 0; w < `SECTOR_WORDS; w++) begin
				buf_req.wr   = is_load;
				buf_req.lba  = 15'(s);
				buf_req.word = 8'(w);
				buf_req.data = rand_word();
				buf_rd       = !is_load;
				step();
			end
			buf_req.wr    = 1'b0;
			buf_rd        = 1'b0;
			credit_return = 1'b1;
			step();
			credit_return = 1'b0;
		end
		while (bk_busy) begin
			step();
		end
		repeat (2) step();
	endtask

	initial begin
		#(2 * TEST_CYCLES * CLK_NS);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Verification failed");
		$fatal(1);
	end

	initial begin
		logic [15:0] data;
		rng           = 32'hea19a91a;
		dl            = '0;
		header_mode   = cart_pkg::HDR_AUTO;
		image         = '0;
		cmd           = '0;
		console       = '0;
		buf_req       = '0;
		credit_return = 1'b0;
		buf_rd        = 1'b0;
		exp_write     = 1'b0;
		pending_armed = 1'b0;
		exp_cheat     = '0;
		wait (reset);
		step();

		// Auto header, RAM size 0 first
		data = rand_word();
		data[7:0] = {4'h0, data[3:0] | 4'h1};
		put_word(cart_pkg::DL_CART, 24'd0, data);
		put_word(cart_pkg::DL_CART, 24'd2, rand_word());
		data = rand_word();
		data[4] = 1'b1;
		put_word(cart_pkg::DL_CART, 24'd0, data);
		repeat (2) step();

		// HiROM header fields
		header_mode = cart_pkg::HDR_HIROM;
		put_word(cart_pkg::DL_CART, 24'd0, rand_word());
		put_word(cart_pkg::DL_CART, `CART_HIROM_HDR + `CART_COPIER_OFS, rand_word());
		put_word(cart_pkg::DL_CART, `CART_HIROM_HDR + `CART_COPIER_OFS + 24'd2, rand_word());
		repeat (2) step();

		send_cheat(24'h000000);
		send_cheat(24'h000010);

		// Cartridge with 2 KB of backup RAM
		header_mode = cart_pkg::HDR_AUTO;
		image       = '{mounted: 1'b1, readonly: 1'b0, nonempty: 1'b0};
		for (int i = 0; i < 1024; i++) begin
			data = rand_word();
			if (i == 0) begin
				data[7:0] = 8'h1C;
			end
			put_word(cart_pkg::DL_CART, 24'(2 * i), data);
		end
		repeat (3) step();
		for (int i = 0; i < 16; i++) begin
			console_access(1'b0, 20'(rand_word() & 16'h07FF), 8'h00);
		end
		pending_armed = 1'b1;
		data = rand_word();
		console_access(1'b1, 20'h00123, data[7:0]);
		console_access(1'b0, 20'h00123, 8'h00);
		pending_armed = 1'b0;
		step();

		// Save to storage
		exp_write = 1'b1;
		cmd.save  = 1'b1;
		step();
		cmd.save = 1'b0;
		serve_sectors(1'b0);

		// Load from storage
		exp_write = 1'b0;
		cmd.load  = 1'b1;
		step();
		cmd.load = 1'b0;
		serve_sectors(1'b1);
		for (int i = 0; i < 32; i++) begin
			console_access(1'b0, 20'(rand_word() & 16'h07FF), 8'h00);
		end
		repeat (2) step();

		if (cheat_pulses != 2) begin
			report_failure("cheat_valid pulse count wrong");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

// ==== dv/tb_clock_gen.sv ====
//====================
// Testbench clock and reset
//====================
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	localparam int PERIOD_NS    = 40;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Active low, released just after a rising edge
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b1;
	end

endmodule

// ==== hw/backup_ram.sv ====
//====================
// Backup RAM
// Byte port for the console, word port for storage
//====================
`timescale 1ns/10ps
`include "cart_macros.svh"

module backup_ram (
	input  logic                 clk_sys,
	input  cart_pkg::dl_word_t   dl,
	input  cart_pkg::bsram_req_t console,
	output logic [7:0]           console_q,
	input  cart_pkg::buf_req_t   buf_req,
	output logic [15:0]          buf_q
);

	localparam int WORD_AW   = `BSRAM_BITS - 1;
	localparam int WORD_BITS = $clog2(`SECTOR_WORDS);

	logic               dl_cart;
	logic               console_wr;
	logic [WORD_AW-1:0] a_addr;
	logic [WORD_AW-1:0] b_addr;
	logic               a_lane_q;
	logic [7:0]         a_q [2];

	assign dl_cart    = dl.wr && (dl.target == cart_pkg::DL_CART);
	assign console_wr = console.ce && console.we;
	assign a_addr     = dl_cart ? dl.addr[`BSRAM_BITS-1:1] : console.addr[`BSRAM_BITS-1:1];
	assign b_addr     = {buf_req.lba[WORD_AW-WORD_BITS-1:0], buf_req.word[WORD_BITS-1:0]};

	// Even bytes in lane 0, odd bytes in lane 1
	for (genvar lane = 0; lane < 2; lane++) begin : g_lane
		logic [7:0] mem [2**WORD_AW];
		logic       a_we;
		logic [7:0] a_data;

		// A cartridge word overwrites both of its bytes with their own address low byte
		assign a_we   = dl_cart || (console_wr && console.addr[0] == lane);
		assign a_data = dl_cart ? {dl.addr[7:1], 1'(lane)} : console.data;

		always_ff @(posedge clk_sys) begin
			a_q[lane] <= mem[a_addr];
			if (a_we) begin
				mem[a_addr] <= a_data;
			end
			buf_q[8*lane +: 8] <= mem[b_addr];
			if (buf_req.wr) begin
				mem[b_addr] <= buf_req.data[8*lane +: 8];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		a_lane_q <= console.addr[0];
	end

	assign console_q = a_q[a_lane_q];

	// Console must stay off the bus while a cartridge streams in
	assert property (@(posedge clk_sys) !(dl_cart && console_wr))
		else $error("console write during cartridge download");

endmodule

// ==== hw/backup_sequencer.sv ====
//====================
// Backup sequencer
// Load, save and autosave over a credit-based storage link
//====================
`timescale 1ns/10ps
`include "cart_macros.svh"

module backup_sequencer (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::dl_word_t    dl,
	input  cart_pkg::rom_info_t   rom_info,
	input  cart_pkg::image_t      image,
	input  cart_pkg::bk_cmd_t     cmd,
	input  cart_pkg::bsram_req_t  console,
	input  logic                  credit_return,
	output cart_pkg::sector_req_t sector_req,
	output logic                  bk_busy,
	output logic                  bk_loading,
	output logic                  bk_pending
);

	localparam int CREDIT_W = $clog2(`BK_CREDITS + 1);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN
	} state_t;

	state_t                  state;
	logic [CREDIT_W-1:0]     credits;
	logic                    cart_word;
	logic                    cart_word_q;
	logic                    bk_ena;
	logic                    bk_save;
	logic                    load_q, load_qq;
	logic                    save_q, save_qq;
	logic                    dl_end;
	logic                    start;
	logic                    start_load;
	logic                    issue;
	logic                    complete;
	logic [`CART_ADDR_W-1:0] mask_sectors;
	logic [14:0]             next_lba;
	logic                    all_issued;
	logic                    all_done;

	// A cartridge arrives as one unbroken burst of words
	assign cart_word = dl.wr && (dl.target == cart_pkg::DL_CART);
	assign bk_save   = cmd.save || (bk_pending && cmd.osd_open && cmd.autosave);

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cart_word_q <= 1'b0;
			bk_ena      <= 1'b0;
			load_q      <= 1'b0;
			load_qq     <= 1'b0;
			save_q      <= 1'b0;
			save_qq     <= 1'b0;
		end else begin
			cart_word_q <= cart_word;
			if (cart_word && !cart_word_q) begin
				bk_ena <= 1'b0;
			end
			if (cart_word && image.mounted && !image.readonly) begin
				bk_ena <= |rom_info.ram_mask;
			end
			load_q  <= cmd.load && bk_ena;
			load_qq <= load_q;
			save_q  <= bk_save && bk_ena;
			save_qq <= save_q;
		end
	end

	// Fresh cartridge with a save image pulls the backup in
	assign dl_end     = cart_word_q && !cart_word && image.nonempty && bk_ena;
	assign start_load = dl_end || (load_q && !load_qq);
	assign start      = (state == IDLE) && (start_load || (save_q && !save_qq));

	assign issue    = (state == RUN) && (credits != '0) && !all_issued;
	assign complete = credit_return && (state != IDLE);

	assign mask_sectors = rom_info.ram_mask >> `SECTOR_BITS;

	sector_counter i_sector_counter (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.start      (start),
		.last_lba   (mask_sectors[14:0]),
		.issue      (issue),
		.complete   (complete),
		.next_lba   (next_lba),
		.all_issued (all_issued),
		.all_done   (all_done)
	);

	//====================
	// Transfer FSM
	//====================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= IDLE;
			bk_loading <= 1'b0;
			credits    <= CREDIT_W'(`BK_CREDITS);
			sector_req <= '0;
		end else begin
			credits          <= credits - CREDIT_W'(issue) + CREDIT_W'(credit_return);
			sector_req.valid <= issue;
			sector_req.write <= !bk_loading;
			sector_req.lba   <= next_lba;
			case (state)
				IDLE: begin
					if (start) begin
						state      <= RUN;
						bk_loading <= start_load;
					end
				end
				RUN, DRAIN: begin
					if (all_done) begin
						state      <= IDLE;
						bk_loading <= 1'b0;
					end else if (all_issued) begin
						state <= DRAIN;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign bk_busy = (state != IDLE);

	// Dirty flag
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_pending <= 1'b0;
		end else if (start) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !cmd.osd_open && console.ce && console.we) begin
			bk_pending <= 1'b1;
		end
	end

	// Storage returns no more credits than it was handed
	assert property (@(posedge clk_sys) disable iff (!reset) credits <= `BK_CREDITS)
		else $error("storage credit overflow");

endmodule

// ==== hw/cart_loader_top.sv ====
//====================
// Cartridge loader top level
//====================
`timescale 1ns/10ps

module cart_loader_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cart_pkg::dl_word_t     dl,
	input  cart_pkg::header_mode_t header_mode,
	input  cart_pkg::image_t       image,
	input  cart_pkg::bk_cmd_t      cmd,
	input  cart_pkg::bsram_req_t   console,
	output logic [7:0]             console_q,
	input  cart_pkg::buf_req_t     buf_req,
	output logic [15:0]            buf_q,
	output cart_pkg::sector_req_t  sector_req,
	input  logic                   credit_return,
	output cart_pkg::rom_info_t    rom_info,
	output cart_pkg::cheat_code_t  cheat,
	output logic                   cheat_valid,
	output logic                   bk_busy,
	output logic                   bk_loading,
	output logic                   bk_pending
);

	rom_header_detect i_rom_header_detect (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.header_mode (header_mode),
		.rom_info    (rom_info)
	);

	cheat_code_assembler i_cheat_code_assembler (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.cheat       (cheat),
		.cheat_valid (cheat_valid)
	);

	backup_ram i_backup_ram (
		.clk_sys   (clk_sys),
		.dl        (dl),
		.console   (console),
		.console_q (console_q),
		.buf_req   (buf_req),
		.buf_q     (buf_q)
	);

	backup_sequencer i_backup_sequencer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl            (dl),
		.rom_info      (rom_info),
		.image         (image),
		.cmd           (cmd),
		.console       (console),
		.credit_return (credit_return),
		.sector_req    (sector_req),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending)
	);

endmodule

// ==== hw/cart_macros.svh ====
//====================
// Cartridge loader constants
// Widths, header offsets and backup storage sizing
//====================
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

// Download stream
`define CART_ADDR_W           24
`define CART_WORD_W           16

// ROM header layout
`define CART_COPIER_OFS       24'h000200
`define CART_LOROM_HDR        24'h007FD6
`define CART_HIROM_HDR        24'h00FFD6
`define CART_EXHIROM_HDR      24'h40FFD6
`define CART_DEFAULT_ROM_SIZE 4'hC

// Backup RAM and storage link
`define BSRAM_BITS            17
`define SECTOR_WORDS          256
`define SECTOR_BITS           9
`define BK_CREDITS            2

`endif

// ==== hw/cart_pkg.sv ====
//====================
// Shared types for the cartridge loader
//====================
`include "cart_macros.svh"

package cart_pkg;

	typedef enum logic {
		DL_CART,
		DL_CODE
	} dl_target_t;

	// One word of the download stream
	typedef struct packed {
		logic                     wr;
		dl_target_t               target;
		logic [`CART_ADDR_W-1:0]  addr;
		logic [`CART_WORD_W-1:0]  data;
	} dl_word_t;

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_t;

	typedef struct packed {
		logic [7:0]              rom_type;
		logic [`CART_ADDR_W-1:0] rom_mask;
		logic [`CART_ADDR_W-1:0] ram_mask;
		logic                    region;
	} rom_info_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic mounted;
		logic readonly;
		logic nonempty;
	} image_t;

	typedef struct packed {
		logic load;
		logic save;
		logic autosave;
		logic osd_open;
	} bk_cmd_t;

	// Console side of the backup RAM
	typedef struct packed {
		logic        ce;
		logic        we;
		logic [19:0] addr;
		logic [7:0]  data;
	} bsram_req_t;

	// write set means the sector goes out to storage
	typedef struct packed {
		logic        valid;
		logic        write;
		logic [14:0] lba;
	} sector_req_t;

	typedef struct packed {
		logic        wr;
		logic [14:0] lba;
		logic [7:0]  word;
		logic [15:0] data;
	} buf_req_t;

endpackage

// ==== hw/cheat_code_assembler.sv ====
//====================
// Cheat code assembler
//====================
`timescale 1ns/10ps

module cheat_code_assembler (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::dl_word_t    dl,
	output cart_pkg::cheat_code_t cheat,
	output logic                  cheat_valid
);

	logic code_word;

	assign code_word = dl.wr && (dl.target == cart_pkg::DL_CODE);

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_word && (dl.addr[3:0] == 4'd14);
		end
	end

	// Eight words per code, low half first
	always_ff @(posedge clk_sys) begin
		if (code_word) begin
			case (dl.addr[3:0])
				4'd0:  cheat.flags[15:0]    <= dl.data;
				4'd2:  cheat.flags[31:16]   <= dl.data;
				4'd4:  cheat.addr[15:0]     <= dl.data;
				4'd6:  cheat.addr[31:16]    <= dl.data;
				4'd8:  cheat.compare[15:0]  <= dl.data;
				4'd10: cheat.compare[31:16] <= dl.data;
				4'd12: cheat.replace[15:0]  <= dl.data;
				4'd14: cheat.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

endmodule

// ==== hw/rom_header_detect.sv ====
//====================
// ROM header detection
// Derives ROM type, masks and region from the cartridge download
//====================
`timescale 1ns/10ps
`include "cart_macros.svh"

module rom_header_detect (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  cart_pkg::dl_word_t      dl,
	input  cart_pkg::header_mode_t  header_mode,
	output cart_pkg::rom_info_t     rom_info
);

	logic                    cart_word;
	logic [3:0]              rom_size;
	logic [3:0]              ram_size;
	logic [3:0]              rom_size_nx;
	logic [3:0]              ram_size_nx;
	logic [`CART_ADDR_W-1:0] field_addr;
	logic                    field_en;

	assign cart_word = dl.wr && (dl.target == cart_pkg::DL_CART);

	// Size field location for the fixed layouts
	always_comb begin
		field_en = 1'b1;
		case (header_mode)
			cart_pkg::HDR_LOROM:   field_addr = `CART_LOROM_HDR + `CART_COPIER_OFS;
			cart_pkg::HDR_HIROM:   field_addr = `CART_HIROM_HDR + `CART_COPIER_OFS;
			cart_pkg::HDR_EXHIROM: field_addr = `CART_EXHIROM_HDR + `CART_COPIER_OFS;
			default: begin
				field_addr = '0;
				field_en   = 1'b0;
			end
		endcase
	end

	// Sizes as they stand after the current word
	always_comb begin
		rom_size_nx = rom_size;
		ram_size_nx = ram_size;
		if (dl.addr == '0) begin
			rom_size_nx = `CART_DEFAULT_ROM_SIZE;
			ram_size_nx = 4'h0;
			// Copier header packs RAM size in the upper nibble
			if (header_mode == cart_pkg::HDR_AUTO && dl.data[7:0] != 8'h00) begin
				{ram_size_nx, rom_size_nx} = dl.data[7:0];
			end
		end
		if (field_en && dl.addr == field_addr) begin
			rom_size_nx = dl.data[11:8];
		end
		if (field_en && dl.addr == field_addr + `CART_ADDR_W'd2) begin
			ram_size_nx = dl.data[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size <= 4'h0;
			ram_size <= 4'h0;
			rom_info <= '0;
		end else if (cart_word) begin
			rom_size <= rom_size_nx;
			ram_size <= ram_size_nx;
			if (dl.addr == '0) begin
				case (header_mode)
					cart_pkg::HDR_NONE,
					cart_pkg::HDR_LOROM:   rom_info.rom_type <= 8'd0;
					cart_pkg::HDR_HIROM:   rom_info.rom_type <= 8'd1;
					cart_pkg::HDR_EXHIROM: rom_info.rom_type <= 8'd2;
					default:               rom_info.rom_type <= dl.data[15:8];
				endcase
			end
			if (dl.addr == `CART_ADDR_W'd2) begin
				rom_info.region <= dl.data[8];
			end
			rom_info.rom_mask <= (`CART_ADDR_W'd1024 << rom_size_nx) - `CART_ADDR_W'd1;
			rom_info.ram_mask <= (ram_size_nx == 4'h0) ? '0 :
				(`CART_ADDR_W'd1024 << ram_size_nx) - `CART_ADDR_W'd1;
		end
	end

endmodule

// ==== hw/sector_counter.sv ====
//====================
// Sector issue and completion counters
//====================
`timescale 1ns/10ps

module sector_counter (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        start,
	input  logic [14:0] last_lba,
	input  logic        issue,
	input  logic        complete,
	output logic [14:0] next_lba,
	output logic        all_issued,
	output logic        all_done
);

	logic [15:0] issue_cnt;
	logic [15:0] done_cnt;
	logic [15:0] total;

	assign total = {1'b0, last_lba} + 16'd1;

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			issue_cnt <= '0;
			done_cnt  <= '0;
		end else if (start) begin
			issue_cnt <= '0;
			done_cnt  <= '0;
		end else begin
			issue_cnt <= issue_cnt + 16'(issue);
			done_cnt  <= done_cnt + 16'(complete);
		end
	end

	assign next_lba   = issue_cnt[14:0];
	assign all_issued = (issue_cnt == total);
	// Counts the completion arriving this cycle
	assign all_done   = ((done_cnt + 16'(complete)) == total);

	// Storage cannot finish a sector that was never requested
	assert property (@(posedge clk_sys) disable iff (!reset) done_cnt <= issue_cnt)
		else $error("sector completions ahead of requests");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the cartridge loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module cart_loader_tb -o sim_cart_loader
./obj_dir/sim_cart_loader | tee sim.log

if grep -q "Verification failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
grep -q "Verification passed" sim.log
echo "Simulation finished cleanly"

// ==== verilog.f ====
+incdir+hw
hw/cart_pkg.sv
hw/rom_header_detect.sv
hw/cheat_code_assembler.sv
hw/backup_ram.sv
hw/sector_counter.sv
hw/backup_sequencer.sv
hw/cart_loader_top.sv
dv/tb_clock_gen.sv
dv/cart_loader_tb.sv
